/* ati_byte_serializer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ati_consts.svh"

module ati_byte_serializer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`ATI_BUS_W-1:0]   front_word,
    input  ati_pkg::ati_data_type_e front_type,
    input  logic                    empty,
    output logic                    pop,
    output logic [7:0]              s_ati_wdata,
    output logic                    s_ati_wr_req,
    input  logic                    s_ati_wr_available
);

    localparam int IDX_W = $clog2(`ATI_BUS_W / 8);

    logic [IDX_W-1:0] byte_idx;
    logic [IDX_W-1:0] last_idx;
    logic             active;

    // Byte under the index, least significant first
    assign s_ati_wdata = front_word[{byte_idx, 3'b000} +: 8];

    // Last byte index from the entry size
    always_comb begin
        case (front_type)
            ati_pkg::BYTE:  last_idx = '0;
            ati_pkg::WORD:  last_idx = IDX_W'(3);
            ati_pkg::DWORD: last_idx = IDX_W'(`ATI_BUS_W / 8 - 1);
            default:        last_idx = '0;
        endcase
    end

    // Device back-pressure freezes everything
    assign active = ~empty & s_ati_wr_available;

    // Entry done once its last byte is strobed
    assign pop = active & s_ati_wr_req & (byte_idx == last_idx);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            byte_idx     <= '0;
            s_ati_wr_req <= 1'b0;
        end else if (active) begin
            // Strobe toggles, device samples on high cycles
            s_ati_wr_req <= ~s_ati_wr_req;
            if (s_ati_wr_req) begin
                if (pop) begin
                    byte_idx <= '0;
                end else begin
                    byte_idx <= byte_idx + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* ati_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module ati_checker (
    input logic clk,
    input logic rst_n,
    input logic s_ati_rd_req,
    input logic s_ati_wr_req,
    input logic s_ati_wr_available,
    input logic s_atis_rd_available
);

    // Pop acknowledge is a single-cycle pulse
    rd_req_single: assert property (@(posedge clk) disable iff (!rst_n)
        s_ati_rd_req |=> !s_ati_rd_req)
        else $error("s_ati_rd_req high two cycles running");

    // Strobe only starts when the device had room
    wr_req_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(s_ati_wr_req) |-> $past(s_ati_wr_available))
        else $error("s_ati_wr_req rose while s_ati_wr_available was low");

    // Nothing readable while held in reset
    rd_avail_reset: assert property (@(posedge clk)
        (!rst_n && $past(!rst_n)) |-> !s_atis_rd_available)
        else $error("s_atis_rd_available high during reset");

endmodule

bind ati_peripheral_bridge ati_checker i_checker (
    .clk                 (clk),
    .rst_n               (rst_n),
    .s_ati_rd_req        (s_ati_rd_req),
    .s_ati_wr_req        (s_ati_wr_req),
    .s_ati_wr_available  (s_ati_wr_available),
    .s_atis_rd_available (s_atis_rd_available)
);

`default_nettype wire

/* ati_consts.svh */
`ifndef ATI_CONSTS_SVH
`define ATI_CONSTS_SVH

// Stream side widths
`define ATI_BUS_W 64
`define ATI_ADDR_W 64

// Channel field sits in the top address bits
`define ATI_CHANNEL_W 2
`define ATI_CHANNEL_ID 1

// Write buffer entries, one stream word each
`define ATI_TX_DEPTH 4

// Read buffer, split into word blocks
`define ATI_RX_BYTES 32
// Byte 0 of each block carries the amount
`define ATI_BLOCK_BYTES 4

// Idle cycles before a partly filled block is closed
`define ATI_PACKET_TIMEOUT 16

`endif

/* ati_packet_timer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ati_consts.svh"

module ati_packet_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic enable,
    output logic expired
);

    localparam int CNT_W = $clog2(`ATI_PACKET_TIMEOUT + 1);

    logic [CNT_W-1:0] count;

    assign expired = count == CNT_W'(`ATI_PACKET_TIMEOUT);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!enable) begin
            // Any activity restarts the idle count
            count <= '0;
        end else if (!expired) begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* ati_peripheral_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ati_consts.svh"

module ati_peripheral_bridge (
    input  logic                    clk,
    input  logic                    rst_n,
    // Stream side
    input  logic [`ATI_BUS_W-1:0]   s_atis_wdata,
    input  logic [`ATI_ADDR_W-1:0]  s_atis_addr,
    input  logic                    s_atis_wr_req,
    input  logic                    s_atis_rd_req,
    input  ati_pkg::ati_data_type_e s_atis_data_type,
    output ati_pkg::ati_rx_packet_u s_atis_rdata,
    output logic                    s_atis_wr_available,
    output logic                    s_atis_rd_available,
    // Byte-wide device side
    output logic [7:0]              s_ati_wdata,
    output logic                    s_ati_wr_req,
    output logic                    s_ati_rd_req,
    input  logic [7:0]              s_ati_rdata,
    input  logic                    s_ati_wr_available,
    input  logic                    s_ati_rd_available
);

    // Write side hand-off
    logic [`ATI_BUS_W-1:0]   front_word;
    ati_pkg::ati_data_type_e front_type;
    logic                    empty;
    logic                    pop;

    // Read side hand-off
    logic [2:0]                 rd_block;
    logic [`ATI_RX_BYTES*8-1:0] block_bytes;
    logic [63:0]                block_amount;
    logic [7:0]                 closed_toggle;

    ati_tx_buffer u_tx_buffer (
        .clk                 (clk),
        .rst_n               (rst_n),
        .s_atis_wdata        (s_atis_wdata),
        .s_atis_addr         (s_atis_addr),
        .s_atis_wr_req       (s_atis_wr_req),
        .s_atis_data_type    (s_atis_data_type),
        .s_atis_wr_available (s_atis_wr_available),
        .front_word          (front_word),
        .front_type          (front_type),
        .empty               (empty),
        .pop                 (pop)
    );

    ati_byte_serializer u_serializer (
        .clk                (clk),
        .rst_n              (rst_n),
        .front_word         (front_word),
        .front_type         (front_type),
        .empty              (empty),
        .pop                (pop),
        .s_ati_wdata        (s_ati_wdata),
        .s_ati_wr_req       (s_ati_wr_req),
        .s_ati_wr_available (s_ati_wr_available)
    );

    ati_rx_packer u_rx_packer (
        .clk                (clk),
        .rst_n              (rst_n),
        .s_ati_rdata        (s_ati_rdata),
        .s_ati_rd_available (s_ati_rd_available),
        .s_ati_rd_req       (s_ati_rd_req),
        .rd_block           (rd_block),
        .block_bytes        (block_bytes),
        .block_amount       (block_amount),
        .closed_toggle      (closed_toggle)
    );

    ati_rx_reader u_rx_reader (
        .clk                 (clk),
        .rst_n               (rst_n),
        .s_atis_addr         (s_atis_addr),
        .s_atis_rd_req       (s_atis_rd_req),
        .s_atis_data_type    (s_atis_data_type),
        .s_atis_rdata        (s_atis_rdata),
        .s_atis_rd_available (s_atis_rd_available),
        .block_bytes         (block_bytes),
        .block_amount        (block_amount),
        .closed_toggle       (closed_toggle),
        .rd_block            (rd_block)
    );

endmodule

`default_nettype wire

/* ati_pkg.sv */
`default_nettype none

package ati_pkg;

`include "ati_consts.svh"

    // Stream access size
    typedef enum logic [1:0] {
        BYTE  = 2'd0,
        WORD  = 2'd1,
        DWORD = 2'd2
    } ati_data_type_e;

    // Stream read word, decoded as one block or as a block pair
    typedef union packed {
        struct packed {
            // Zero padding above the block
            logic [`ATI_BUS_W-33:0] pad;
            // First arrived byte in the low byte
            logic [23:0]            data;
            logic [7:0]             amount;
        } word;
        struct packed {
            // Upper block bytes above lower block bytes
            logic [`ATI_BUS_W-17:0] data;
            // Sum of both block amounts
            logic [15:0]            amount;
        } dword;
    } ati_rx_packet_u;

endpackage

`default_nettype wire

/* ati_rx_packer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ati_consts.svh"

module ati_rx_packer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [7:0]                 s_ati_rdata,
    input  logic                       s_ati_rd_available,
    output logic                       s_ati_rd_req,
    input  logic [2:0]                 rd_block,
    output logic [`ATI_RX_BYTES*8-1:0] block_bytes,
    output logic [63:0]                block_amount,
    output logic [7:0]                 closed_toggle
);

    localparam int NUM_BLOCKS = `ATI_RX_BYTES / `ATI_BLOCK_BYTES;
    localparam int BLK_W      = $clog2(NUM_BLOCKS);
    localparam int SLOT_W     = $clog2(`ATI_BLOCK_BYTES);
    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`ATI_BLOCK_BYTES - 1);

    localparam logic OUT_BLOCK = 1'b0;
    localparam logic IN_BLOCK  = 1'b1;

    // Byte 0 of each block holds its amount
    logic [7:0]              buf_mem [0:`ATI_RX_BYTES-1];
    logic                    state;
    logic [BLK_W-1:0]        wr_block;
    logic [SLOT_W-1:0]       slot;
    logic [BLK_W+SLOT_W-1:0] wr_addr;
    logic [BLK_W+SLOT_W-1:0] amt_addr;
    logic                    buf_full;
    logic                    open_blk;
    logic                    store_byte;
    logic                    ack;
    logic                    close_blk;
    logic                    timer_en;
    logic                    timer_expired;

    ati_packet_timer u_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .enable  (timer_en),
        .expired (timer_expired)
    );

    assign wr_addr  = {wr_block, slot};
    assign amt_addr = {wr_block, {SLOT_W{1'b0}}};

    // Keep one block free ahead of the reader
    assign buf_full = (wr_block + 1'b1) == rd_block;

    assign open_blk   = (state == OUT_BLOCK) & s_ati_rd_available & ~buf_full;
    // Byte capture, ack follows on the next cycle
    assign store_byte = (state == IN_BLOCK) & ~s_ati_rd_req & s_ati_rd_available;
    assign ack        = (state == IN_BLOCK) & s_ati_rd_req;
    // Open block waiting for data
    assign timer_en   = (state == IN_BLOCK) & ~s_ati_rd_req & ~s_ati_rd_available;
    // Close on third byte acked or on idle timeout
    assign close_blk  = (ack & (slot == LAST_SLOT)) | (timer_en & timer_expired);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= OUT_BLOCK;
            wr_block      <= '0;
            slot          <= SLOT_W'(1);
            s_ati_rd_req  <= 1'b0;
            closed_toggle <= '0;
        end else begin
            // One-cycle pop acknowledge to the device
            s_ati_rd_req <= store_byte;
            if (open_blk) begin
                state <= IN_BLOCK;
                slot  <= SLOT_W'(1);
            end
            if (ack && !close_blk) begin
                slot <= slot + 1'b1;
            end
            if (close_blk) begin
                state    <= OUT_BLOCK;
                wr_block <= wr_block + 1'b1;
                // Hands the block over to the reader
                closed_toggle[wr_block] <= ~closed_toggle[wr_block];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (open_blk) begin
            buf_mem[amt_addr] <= 8'd0;
        end
        if (store_byte) begin
            buf_mem[wr_addr]  <= s_ati_rdata;
            buf_mem[amt_addr] <= buf_mem[amt_addr] + 8'd1;
        end
    end

    // Flattened views for the reader
    for (genvar i = 0; i < `ATI_RX_BYTES; i++) begin : g_bytes
        assign block_bytes[i*8 +: 8] = buf_mem[i];
    end

    for (genvar b = 0; b < NUM_BLOCKS; b++) begin : g_amount
        assign block_amount[b*8 +: 8] = buf_mem[b*`ATI_BLOCK_BYTES];
    end

endmodule

`default_nettype wire

/* ati_rx_reader.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ati_consts.svh"

module ati_rx_reader (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`ATI_ADDR_W-1:0]     s_atis_addr,
    input  logic                       s_atis_rd_req,
    input  ati_pkg::ati_data_type_e    s_atis_data_type,
    output ati_pkg::ati_rx_packet_u    s_atis_rdata,
    output logic                       s_atis_rd_available,
    input  logic [`ATI_RX_BYTES*8-1:0] block_bytes,
    input  logic [63:0]                block_amount,
    input  logic [7:0]                 closed_toggle,
    output logic [2:0]                 rd_block
);

    localparam int BLOCK_W = `ATI_BLOCK_BYTES * 8;

    logic [7:0]         consumed_toggle;
    logic [7:0]         valid;
    logic [2:0]         rd_next;
    logic               channel_hit;
    logic               take;
    logic               pair_read;
    logic [BLOCK_W-9:0] cur_data;
    logic [BLOCK_W-9:0] next_data;
    logic [7:0]         cur_amt;
    logic [7:0]         next_amt;

    assign channel_hit = s_atis_addr[`ATI_ADDR_W-1 -: `ATI_CHANNEL_W]
                         == `ATI_CHANNEL_W'(`ATI_CHANNEL_ID);

    // Closed but not yet consumed
    assign valid   = closed_toggle ^ consumed_toggle;
    assign rd_next = rd_block + 3'd1;

    // Data bytes sit above the amount byte
    assign cur_data  = block_bytes[rd_block*BLOCK_W + 8 +: BLOCK_W-8];
    assign next_data = block_bytes[rd_next*BLOCK_W + 8 +: BLOCK_W-8];
    assign cur_amt   = block_amount[rd_block*8 +: 8];
    assign next_amt  = block_amount[rd_next*8 +: 8];

    always_comb begin
        s_atis_rdata        = '0;
        s_atis_rd_available = 1'b0;
        pair_read           = 1'b0;
        case (s_atis_data_type)
            // Byte reads come back word aligned
            ati_pkg::BYTE, ati_pkg::WORD: begin
                s_atis_rdata.word.data   = cur_data;
                s_atis_rdata.word.amount = cur_amt;
                s_atis_rd_available      = valid[rd_block];
            end
            ati_pkg::DWORD: begin
                s_atis_rdata.dword.data   = {next_data, cur_data};
                s_atis_rdata.dword.amount = 16'(cur_amt) + 16'(next_amt);
                s_atis_rd_available       = valid[rd_block] & valid[rd_next];
                pair_read                 = 1'b1;
            end
            default: begin
                s_atis_rdata.word.data   = cur_data;
                s_atis_rdata.word.amount = cur_amt;
            end
        endcase
    end

    assign take = channel_hit & s_atis_rd_req & s_atis_rd_available;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            consumed_toggle <= '0;
            rd_block        <= '0;
        end else if (take) begin
            consumed_toggle[rd_block] <= ~consumed_toggle[rd_block];
            if (pair_read) begin
                // Second block of the pair goes too
                consumed_toggle[rd_next] <= ~consumed_toggle[rd_next];
                rd_block <= rd_block + 3'd2;
            end else begin
                rd_block <= rd_next;
            end
        end
    end

endmodule

`default_nettype wire

/* ati_tx_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ati_consts.svh"

module ati_tx_buffer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`ATI_BUS_W-1:0]   s_atis_wdata,
    input  logic [`ATI_ADDR_W-1:0]  s_atis_addr,
    input  logic                    s_atis_wr_req,
    input  ati_pkg::ati_data_type_e s_atis_data_type,
    output logic                    s_atis_wr_available,
    output logic [`ATI_BUS_W-1:0]   front_word,
    output ati_pkg::ati_data_type_e front_type,
    output logic                    empty,
    input  logic                    pop
);

    localparam int PTR_W = $clog2(`ATI_TX_DEPTH);

    // Entry storage, word and its access size
    logic [`ATI_BUS_W-1:0]   word_mem [0:`ATI_TX_DEPTH-1];
    ati_pkg::ati_data_type_e type_mem [0:`ATI_TX_DEPTH-1];

    // Extra wrap bit tells full from empty
    logic [PTR_W:0] rear_ptr;
    logic [PTR_W:0] front_ptr;
    logic           channel_hit;
    logic           full;
    logic           push;

    // Request counts only for our channel
    assign channel_hit = s_atis_addr[`ATI_ADDR_W-1 -: `ATI_CHANNEL_W]
                         == `ATI_CHANNEL_W'(`ATI_CHANNEL_ID);

    assign full  = (rear_ptr[PTR_W] != front_ptr[PTR_W])
                   && (rear_ptr[PTR_W-1:0] == front_ptr[PTR_W-1:0]);
    assign empty = rear_ptr == front_ptr;

    // Writes into a full buffer are dropped
    assign push = channel_hit & s_atis_wr_req & ~full;
    assign s_atis_wr_available = ~full;

    // Front entry goes to the serializer
    assign front_word = word_mem[front_ptr[PTR_W-1:0]];
    assign front_type = type_mem[front_ptr[PTR_W-1:0]];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rear_ptr  <= '0;
            front_ptr <= '0;
        end else begin
            if (push) begin
                rear_ptr <= rear_ptr + 1'b1;
            end
            // Serializer has sent the last byte of the front entry
            if (pop && !empty) begin
                front_ptr <= front_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            word_mem[rear_ptr[PTR_W-1:0]] <= s_atis_wdata;
            type_mem[rear_ptr[PTR_W-1:0]] <= s_atis_data_type;
        end
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
ati_pkg.sv
ati_tx_buffer.sv
ati_byte_serializer.sv
ati_packet_timer.sv
ati_rx_packer.sv
ati_rx_reader.sv
ati_peripheral_bridge.sv
ati_checker.sv
tb_ati.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_ati -o tb_ati_sim

output=$(./obj_dir/tb_ati_sim)
echo "$output"

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

/* tb_ati.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ati_consts.svh"

module tb_ati;

    localparam int K_WRITE   = 0;
    localparam int K_DRAIN   = 1;
    localparam int K_HOLD    = 2;
    localparam int K_FULL    = 3;
    localparam int K_RELEASE = 4;
    localparam int K_FEED    = 5;
    localparam int K_READ    = 6;
    localparam int K_EMPTY   = 7;
    localparam logic [1:0] CH = 2'(`ATI_CHANNEL_ID);

    logic                    clk;
    logic                    rst_n;
    logic [`ATI_BUS_W-1:0]   s_atis_wdata;
    logic [`ATI_ADDR_W-1:0]  s_atis_addr;
    logic                    s_atis_wr_req;
    logic                    s_atis_rd_req;
    ati_pkg::ati_data_type_e s_atis_data_type;
    ati_pkg::ati_rx_packet_u s_atis_rdata;
    logic                    s_atis_wr_available;
    logic                    s_atis_rd_available;
    logic [7:0]              s_ati_wdata;
    logic                    s_ati_wr_req;
    logic                    s_ati_rd_req;
    logic [7:0]              s_ati_rdata = 8'h00;
    logic                    s_ati_wr_available;
    logic                    s_ati_rd_available = 1'b0;

    // Stimulus table, one entry per row
    int                      row_kind [$];
    logic [1:0]              row_chan [$];
    ati_pkg::ati_data_type_e row_type [$];
    logic [63:0]             row_data [$];
    int                      row_amt  [$];

    // Device byte records
    logic [7:0]  tx_log [$];
    logic [7:0]  exp_tx [$];
    logic [7:0]  feed_q [$];
    int          feed_head = 0;
    int          drain_checked;
    int          rx_checked;
    logic [31:0] rng;
    int          check_count;
    int          error_count;
    int          cycles = 0;
    int          cycle_limit;

    ati_peripheral_bridge i_dut (
        .clk                 (clk),
        .rst_n               (rst_n),
        .s_atis_wdata        (s_atis_wdata),
        .s_atis_addr         (s_atis_addr),
        .s_atis_wr_req       (s_atis_wr_req),
        .s_atis_rd_req       (s_atis_rd_req),
        .s_atis_data_type    (s_atis_data_type),
        .s_atis_rdata        (s_atis_rdata),
        .s_atis_wr_available (s_atis_wr_available),
        .s_atis_rd_available (s_atis_rd_available),
        .s_ati_wdata         (s_ati_wdata),
        .s_ati_wr_req        (s_ati_wr_req),
        .s_ati_rd_req        (s_ati_rd_req),
        .s_ati_rdata         (s_ati_rdata),
        .s_ati_wr_available  (s_ati_wr_available),
        .s_ati_rd_available  (s_ati_rd_available)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Run limit from the table length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: no progress within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Device model, logs written bytes and serves the feed queue
    always @(posedge clk) begin : device_model
        int head;
        // Device takes a byte on every high strobe cycle
        if (s_ati_wr_req) begin
            tx_log.push_back(s_ati_wdata);
        end
        head = feed_head;
        // Pop on the acknowledge
        if (s_ati_rd_req && head < feed_q.size()) begin
            head = head + 1;
        end
        feed_head          <= head;
        s_ati_rd_available <= head < feed_q.size();
        if (head < feed_q.size()) begin
            s_ati_rdata <= feed_q[head];
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state ^ (state << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Bytes sent per access size
    function automatic int byte_count(input ati_pkg::ati_data_type_e dtype);
        case (dtype)
            ati_pkg::BYTE:  return 1;
            ati_pkg::WORD:  return 4;
            default:        return 8;
        endcase
    endfunction

    function automatic string kind_name(input int kind);
        case (kind)
            K_WRITE:   return "write";
            K_DRAIN:   return "drain";
            K_HOLD:    return "hold";
            K_FULL:    return "full";
            K_RELEASE: return "release";
            K_FEED:    return "feed";
            K_READ:    return "read";
            default:   return "empty";
        endcase
    endfunction

    task automatic add_row(input int kind, input logic [1:0] chan,
                           input ati_pkg::ati_data_type_e dtype, input int amount);
        logic [63:0] data;
        rng = xorshift32(rng);
        data[63:32] = rng;
        rng = xorshift32(rng);
        data[31:0] = rng;
        row_kind.push_back(kind);
        row_chan.push_back(chan);
        row_type.push_back(dtype);
        row_data.push_back(data);
        row_amt.push_back(amount);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("Fail at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic write_word(input logic [1:0] chan, input ati_pkg::ati_data_type_e dtype,
                              input logic [63:0] data);
        // Respect the buffer level
        @(negedge clk);
        while (!s_atis_wr_available) begin
            @(negedge clk);
        end
        @(posedge clk);
        s_atis_addr      <= {chan, {(`ATI_ADDR_W-`ATI_CHANNEL_W){1'b0}}};
        s_atis_wdata     <= data;
        s_atis_data_type <= dtype;
        s_atis_wr_req    <= 1'b1;
        @(posedge clk);
        s_atis_wr_req <= 1'b0;
        // Other channels must leave no bytes
        if (chan == CH) begin
            for (int i = 0; i < byte_count(dtype); i++) begin
                exp_tx.push_back(data[i*8 +: 8]);
            end
        end
    endtask

    task automatic drain_check();
        @(negedge clk);
        while (tx_log.size() < exp_tx.size()) begin
            @(negedge clk);
        end
        check_value("device byte count", 64'(tx_log.size()), 64'(exp_tx.size()));
        for (int i = drain_checked; i < exp_tx.size(); i++) begin
            check_value("s_ati_wdata", 64'(tx_log[i]), 64'(exp_tx[i]));
        end
        drain_checked = exp_tx.size();
    endtask

    task automatic feed_bytes(input logic [63:0] data, input int amount);
        @(negedge clk);
        for (int i = 0; i < amount; i++) begin
            feed_q.push_back(data[i*8 +: 8]);
        end
    endtask

    task automatic read_packet(input ati_pkg::ati_data_type_e dtype, input int amount);
        @(posedge clk);
        s_atis_addr      <= {CH, {(`ATI_ADDR_W-`ATI_CHANNEL_W){1'b0}}};
        s_atis_data_type <= dtype;
        // Wait for the closed block or block pair
        @(negedge clk);
        while (!s_atis_rd_available) begin
            @(negedge clk);
        end
        if (dtype == ati_pkg::DWORD) begin
            check_value("s_atis_rdata.dword.amount", 64'(s_atis_rdata.dword.amount),
                        64'(amount));
            for (int i = 0; i < amount; i++) begin
                check_value("s_atis_rdata.dword.data", 64'(s_atis_rdata.dword.data[i*8 +: 8]),
                            64'(feed_q[rx_checked+i]));
            end
        end else begin
            check_value("s_atis_rdata.word.pad", 64'(s_atis_rdata.word.pad), 64'(0));
            check_value("s_atis_rdata.word.amount", 64'(s_atis_rdata.word.amount),
                        64'(amount));
            // Only the valid bytes count
            for (int i = 0; i < amount; i++) begin
                check_value("s_atis_rdata.word.data", 64'(s_atis_rdata.word.data[i*8 +: 8]),
                            64'(feed_q[rx_checked+i]));
            end
        end
        rx_checked += amount;
        @(posedge clk);
        s_atis_rd_req <= 1'b1;
        @(posedge clk);
        s_atis_rd_req <= 1'b0;
    endtask

    initial begin : main
        int start_errors;
        s_atis_wdata       <= '0;
        s_atis_addr        <= '0;
        s_atis_wr_req      <= 1'b0;
        s_atis_rd_req      <= 1'b0;
        s_atis_data_type   <= ati_pkg::BYTE;
        s_ati_wr_available <= 1'b1;
        rst_n              <= 1'b0;
        rng           = 32'h20bb;
        check_count   = 0;
        error_count   = 0;
        drain_checked = 0;
        rx_checked    = 0;

        // Serialization of all three sizes
        add_row(K_WRITE, CH, ati_pkg::BYTE, 0);
        add_row(K_WRITE, CH, ati_pkg::WORD, 0);
        add_row(K_WRITE, CH, ati_pkg::DWORD, 0);
        add_row(K_DRAIN, CH, ati_pkg::BYTE, 0);
        // Foreign channels filtered
        add_row(K_WRITE, 2'd2, ati_pkg::DWORD, 0);
        add_row(K_WRITE, 2'd0, ati_pkg::WORD, 0);
        add_row(K_WRITE, CH, ati_pkg::BYTE, 0);
        add_row(K_DRAIN, CH, ati_pkg::BYTE, 0);
        // Device back-pressure fills the buffer
        add_row(K_HOLD, CH, ati_pkg::BYTE, 0);
        add_row(K_WRITE, CH, ati_pkg::DWORD, 0);
        add_row(K_WRITE, CH, ati_pkg::WORD, 0);
        add_row(K_WRITE, CH, ati_pkg::BYTE, 0);
        add_row(K_WRITE, CH, ati_pkg::DWORD, 0);
        add_row(K_FULL, CH, ati_pkg::BYTE, 0);
        add_row(K_RELEASE, CH, ati_pkg::BYTE, 0);
        add_row(K_DRAIN, CH, ati_pkg::BYTE, 0);
        // Full block, timeout block, block pair
        add_row(K_FEED, CH, ati_pkg::WORD, 3);
        add_row(K_READ, CH, ati_pkg::WORD, 3);
        add_row(K_FEED, CH, ati_pkg::WORD, 2);
        add_row(K_READ, CH, ati_pkg::WORD, 2);
        add_row(K_FEED, CH, ati_pkg::DWORD, 6);
        add_row(K_READ, CH, ati_pkg::DWORD, 6);
        add_row(K_EMPTY, CH, ati_pkg::DWORD, 0);
        cycle_limit = 200 * row_kind.size() + 10;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("s_ati_wr_req", 64'(s_ati_wr_req), 64'(0));
        check_value("s_ati_rd_req", 64'(s_ati_rd_req), 64'(0));
        check_value("s_atis_rd_available", 64'(s_atis_rd_available), 64'(0));
        check_value("s_atis_wr_available", 64'(s_atis_wr_available), 64'(1));
        $display("Test reset: %s", (error_count == 0) ? "ok" : "failed");

        for (int i = 0; i < row_kind.size(); i++) begin
            start_errors = error_count;
            case (row_kind[i])
                K_WRITE: write_word(row_chan[i], row_type[i], row_data[i]);
                K_DRAIN: drain_check();
                K_HOLD: begin
                    @(posedge clk);
                    s_ati_wr_available <= 1'b0;
                end
                K_FULL: begin
                    @(negedge clk);
                    check_value("s_atis_wr_available", 64'(s_atis_wr_available), 64'(0));
                    check_value("device byte count", 64'(tx_log.size()), 64'(drain_checked));
                end
                K_RELEASE: begin
                    @(posedge clk);
                    s_ati_wr_available <= 1'b1;
                end
                K_FEED: feed_bytes(row_data[i], row_amt[i]);
                K_READ: read_packet(row_type[i], row_amt[i]);
                default: begin
                    @(negedge clk);
                    check_value("s_atis_rd_available", 64'(s_atis_rd_available), 64'(0));
                end
            endcase
            $display("Test %0d %s: %s", i, kind_name(row_kind[i]),
                     (error_count == start_errors) ? "ok" : "failed");
        end

        $display("Summary: %0d tests, %0d checks, %0d errors",
                 row_kind.size() + 1, check_count, error_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
